/* rtl/sw_cfg_pkg.sv */
package sw_cfg_pkg;

    // shared buffer geometry
    localparam int num_pages  = 64;
    localparam int page_words = 8;

    localparam int num_ports  = 4;
    localparam int num_prios  = 4;
    localparam int num_queues = num_ports * num_prios;

    // a max length packet needs 8 pages
    localparam int full_level        = 8;
    localparam int almost_full_level = 16;

    typedef logic [15:0] word_t;
    typedef logic [5:0]  page_t;
    typedef logic [2:0]  offset_t;
    // 0 to 64 pages
    typedef logic [6:0]  pcount_t;

endpackage

/* rtl/pkt_fmt_pkg.sv */
package pkt_fmt_pkg;

    typedef logic [1:0] port_t;
    typedef logic [1:0] prio_t;
    typedef logic [5:0] len_t;

    // queue id is {port, prio}
    typedef logic [$bits(port_t)+$bits(prio_t)-1:0] qid_t;

    // header word layout
    localparam int dest_lsb = 0;
    localparam int prio_lsb = 2;
    localparam int len_lsb  = 4;

    typedef enum logic {
        ing_idle,
        ing_body
    } ingress_state_t;

    typedef enum logic [1:0] {
        egr_idle,
        egr_header,
        egr_body,
        egr_finish
    } egress_state_t;

endpackage

/* rtl/buf_wr_if.sv */
`timescale 1ns/1ps

interface buf_wr_if import sw_cfg_pkg::*, pkt_fmt_pkg::*; ();

    logic    alloc;
    page_t   alloc_page;
    pcount_t free_count;

    logic    we;
    page_t   waddr_page;
    offset_t waddr_offset;
    word_t   wdata;

    logic    link_we;
    page_t   link_from;
    page_t   link_to;

    logic    enq;
    qid_t    enq_qid;
    page_t   enq_head;
    page_t   enq_tail;

    modport writer (
        output alloc, we, waddr_page, waddr_offset, wdata,
        output link_we, link_from, link_to, enq, enq_qid, enq_head, enq_tail,
        input  alloc_page, free_count
    );

    modport buffer (
        input  alloc, we, waddr_page, waddr_offset, wdata,
        input  link_we, link_from, link_to, enq, enq_qid, enq_head, enq_tail,
        output alloc_page, free_count
    );

endinterface

/* rtl/buf_rd_if.sv */
`timescale 1ns/1ps

interface buf_rd_if import sw_cfg_pkg::*, pkt_fmt_pkg::*; ();

    logic                  re;
    page_t                 raddr_page;
    offset_t               raddr_offset;
    word_t                 rdata;
    page_t                 link_next;

    qid_t                  sel_qid;
    page_t                 head_page;
    logic [num_queues-1:0] queue_busy;

    logic                  release_en;
    page_t                 release_page;

    logic                  deq;
    qid_t                  deq_qid;
    page_t                 deq_next;

    modport reader (
        output re, raddr_page, raddr_offset, sel_qid,
        output release_en, release_page, deq, deq_qid, deq_next,
        input  rdata, link_next, head_page, queue_busy
    );

    modport buffer (
        input  re, raddr_page, raddr_offset, sel_qid,
        input  release_en, release_page, deq, deq_qid, deq_next,
        output rdata, link_next, head_page, queue_busy
    );

endinterface

/* rtl/page_free_list.sv */
`timescale 1ns/1ps

module page_free_list import sw_cfg_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    pop,
    input  logic    push,
    input  page_t   push_page,
    output page_t   top_page,
    output pcount_t count
);

    page_t                ring [num_pages];
    logic [num_pages-1:0] fresh;
    page_t                rd_ptr;
    page_t                wr_ptr;

    // untouched slots still hold their own index
    assign top_page = fresh[rd_ptr] ? rd_ptr : ring[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            ring[wr_ptr] <= push_page;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fresh  <= '1;
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= pcount_t'(num_pages);
        end else begin
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push) begin
                fresh[wr_ptr] <= 1'b0;
                wr_ptr        <= wr_ptr + 1'b1;
            end
            count <= count + pcount_t'(push) - pcount_t'(pop);
        end
    end

    pop_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> count != '0
    );

    push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> count != pcount_t'(num_pages)
    );

endmodule

/* rtl/page_buffer.sv */
`timescale 1ns/1ps

module page_buffer import sw_cfg_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    buf_wr_if.buffer wr,
    buf_rd_if.buffer rd
);

    word_t   data_mem [num_pages][page_words];
    page_t   link_mem [num_pages];
    page_t   q_head   [num_queues];
    page_t   q_tail   [num_queues];
    pcount_t q_count  [num_queues];

    logic    same_queue;
    logic    tail_link;
    logic    enq_to_empty;

    page_free_list free_list_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pop       (wr.alloc),
        .push      (rd.release_en),
        .push_page (rd.release_page),
        .top_page  (wr.alloc_page),
        .count     (wr.free_count)
    );

    assign same_queue = wr.enq && rd.deq && wr.enq_qid == rd.deq_qid;
    assign tail_link  = wr.enq && q_count[wr.enq_qid] != '0;

    // head also moves when this cycle's deq drains the last packet
    assign enq_to_empty = wr.enq && (q_count[wr.enq_qid] == '0 ||
                          (same_queue && q_count[wr.enq_qid] == pcount_t'(1)));

    always_ff @(posedge clk) begin
        if (wr.we) begin
            data_mem[wr.waddr_page][wr.waddr_offset] <= wr.wdata;
        end
        if (rd.re) begin
            rd.rdata <= data_mem[rd.raddr_page][rd.raddr_offset];
        end
    end

    // in-packet link and queue link always name different pages
    always_ff @(posedge clk) begin
        if (wr.link_we) begin
            link_mem[wr.link_from] <= wr.link_to;
        end
        if (tail_link) begin
            link_mem[q_tail[wr.enq_qid]] <= wr.enq_head;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.enq) begin
            q_tail[wr.enq_qid] <= wr.enq_tail;
        end
        if (rd.deq) begin
            q_head[rd.deq_qid] <= rd.deq_next;
        end
        if (enq_to_empty) begin
            q_head[wr.enq_qid] <= wr.enq_head;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int q = 0; q < num_queues; q++) begin
                q_count[q] <= '0;
            end
        end else begin
            if (wr.enq && !same_queue) begin
                q_count[wr.enq_qid] <= q_count[wr.enq_qid] + 1'b1;
            end
            if (rd.deq && !same_queue) begin
                q_count[rd.deq_qid] <= q_count[rd.deq_qid] - 1'b1;
            end
        end
    end

    always_comb begin
        for (int q = 0; q < num_queues; q++) begin
            rd.queue_busy[q] = q_count[q] != '0;
        end
    end

    assign rd.head_page = q_head[rd.sel_qid];
    assign rd.link_next = link_mem[rd.raddr_page];

    deq_from_empty: assert property (
        @(posedge clk) disable iff (!rst_n) rd.deq |-> q_count[rd.deq_qid] != '0
    );

endmodule

/* rtl/pkt_ingress.sv */
`timescale 1ns/1ps

module pkt_ingress import sw_cfg_pkg::*, pkt_fmt_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_sop,
    input  logic     wr_eop,
    input  logic     wr_vld,
    input  word_t    wr_data,
    output logic     full,
    output logic     almost_full,
    buf_wr_if.writer wr
);

    ingress_state_t state;
    offset_t        offset;
    page_t          cur_page;
    page_t          head_page;
    qid_t           qid;
    len_t           pkt_len;
    len_t           word_cnt;

    logic           accept;
    logic           new_page;
    page_t          page_now;
    pcount_t        free_next;

    assign accept   = wr_vld && (state == ing_body || wr_sop);
    // header, or first word past a page boundary
    assign new_page = accept && (state == ing_idle || offset == '0);
    assign page_now = new_page ? wr.alloc_page : cur_page;
    assign wr.alloc = new_page;

    assign free_next = wr.free_count - pcount_t'(new_page);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ing_idle;
            wr.we       <= 1'b0;
            wr.link_we  <= 1'b0;
            wr.enq      <= 1'b0;
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            wr.we       <= accept;
            wr.link_we  <= new_page && state == ing_body;
            wr.enq      <= accept && state == ing_body && wr_eop;
            full        <= free_next < pcount_t'(full_level);
            almost_full <= free_next < pcount_t'(almost_full_level);
            case (state)
                ing_idle: begin
                    if (accept) begin
                        state <= ing_body;
                    end
                end
                ing_body: begin
                    if (accept && wr_eop) begin
                        state <= ing_idle;
                    end
                end
                default: state <= ing_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_page <= page_now;
            offset   <= (state == ing_idle) ? offset_t'(1) : offset + 1'b1;
            word_cnt <= (state == ing_idle) ? len_t'(1) : word_cnt + 1'b1;
        end
        if (accept && state == ing_idle) begin
            head_page <= wr.alloc_page;
            qid       <= {wr_data[dest_lsb +: $bits(port_t)], wr_data[prio_lsb +: $bits(prio_t)]};
            pkt_len   <= wr_data[len_lsb +: $bits(len_t)];
        end
        wr.waddr_page   <= page_now;
        wr.waddr_offset <= (state == ing_idle) ? offset_t'(0) : offset;
        wr.wdata        <= wr_data;
        wr.link_from    <= cur_page;
        wr.link_to      <= wr.alloc_page;
        wr.enq_qid      <= qid;
        wr.enq_head     <= head_page;
        wr.enq_tail     <= page_now;
    end

    sop_while_full: assert property (
        @(posedge clk) disable iff (!rst_n) wr_vld && wr_sop |-> !full
    );

    eop_length: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_vld && wr_eop |-> state == ing_body && word_cnt + len_t'(1) == pkt_len
    );

endmodule

/* rtl/pkt_egress.sv */
`timescale 1ns/1ps

module pkt_egress import sw_cfg_pkg::*, pkt_fmt_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [num_ports-1:0] ready,
    output logic [num_ports-1:0] rd_sop,
    output logic [num_ports-1:0] rd_vld,
    output logic [num_ports-1:0] rd_eop,
    output word_t                rd_data,
    buf_rd_if.reader             rd
);

    egress_state_t        state;
    port_t                last_port;
    port_t                cur_port;
    qid_t                 cur_qid;
    page_t                rd_page;
    offset_t              rd_off;
    len_t                 issued;
    len_t                 pkt_len;
    logic                 first_body;

    logic [num_ports-1:0] port_busy;
    logic [num_ports-1:0] cur_onehot;
    port_t                cand;
    logic                 pick_found;
    port_t                pick_port;
    prio_t                pick_prio;
    len_t                 len_now;
    logic                 issue;
    logic                 last_word;
    logic                 page_end;

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            port_busy[p]  = |rd.queue_busy[p*num_prios +: num_prios];
            cur_onehot[p] = cur_port == port_t'(p);
        end
    end

    // round robin, starting after the last port served
    always_comb begin
        pick_found = 1'b0;
        pick_port  = last_port;
        pick_prio  = '0;
        cand       = last_port;
        for (int i = 1; i <= num_ports; i++) begin
            cand = last_port + port_t'(i);
            if (!pick_found && ready[cand] && port_busy[cand]) begin
                pick_found = 1'b1;
                pick_port  = cand;
            end
        end
        for (int j = num_prios - 1; j >= 0; j--) begin
            if (rd.queue_busy[{pick_port, prio_t'(j)}]) begin
                pick_prio = prio_t'(j);
            end
        end
    end

    // header word is on rdata in the first body cycle
    assign len_now   = first_body ? rd.rdata[len_lsb +: $bits(len_t)] : pkt_len;
    assign issue     = ready[cur_port] && (state == egr_header || state == egr_body);
    assign last_word = state == egr_body && issued + len_t'(1) == len_now;
    assign page_end  = rd_off == offset_t'(page_words - 1);

    assign rd.re           = issue;
    assign rd.raddr_page   = rd_page;
    assign rd.raddr_offset = rd_off;
    assign rd.sel_qid      = {pick_port, pick_prio};
    assign rd.release_en   = (issue && page_end && !last_word) || state == egr_finish;
    assign rd.release_page = rd_page;
    assign rd.deq          = state == egr_finish;
    assign rd.deq_qid      = cur_qid;
    // raddr_page still sits on the last page here
    assign rd.deq_next     = rd.link_next;
    assign rd_data         = rd.rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= egr_idle;
            last_port  <= port_t'(num_ports - 1);
            first_body <= 1'b0;
            rd_sop     <= '0;
            rd_vld     <= '0;
            rd_eop     <= '0;
        end else begin
            rd_vld     <= issue ? cur_onehot : '0;
            rd_sop     <= (issue && state == egr_header) ? cur_onehot : '0;
            rd_eop     <= (issue && last_word) ? cur_onehot : '0;
            first_body <= issue && state == egr_header;
            case (state)
                egr_idle: begin
                    if (pick_found) begin
                        state     <= egr_header;
                        last_port <= pick_port;
                    end
                end
                egr_header: begin
                    if (issue) begin
                        state <= egr_body;
                    end
                end
                egr_body: begin
                    if (issue && last_word) begin
                        state <= egr_finish;
                    end
                end
                default: state <= egr_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == egr_idle) begin
            cur_port <= pick_port;
            cur_qid  <= {pick_port, pick_prio};
            rd_page  <= rd.head_page;
            rd_off   <= '0;
            issued   <= '0;
        end else if (issue) begin
            issued <= issued + 1'b1;
            if (!last_word) begin
                rd_off <= rd_off + 1'b1;
                if (page_end) begin
                    rd_page <= rd.link_next;
                end
            end
        end
        if (first_body) begin
            pkt_len <= len_now;
        end
    end

    one_port_out: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(rd_vld)
    );

endmodule

/* rtl/switch_top.sv */
`timescale 1ns/1ps

module switch_top import sw_cfg_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_sop,
    input  logic                 wr_eop,
    input  logic                 wr_vld,
    input  word_t                wr_data,
    output logic                 full,
    output logic                 almost_full,
    input  logic [num_ports-1:0] ready,
    output logic [num_ports-1:0] rd_sop,
    output logic [num_ports-1:0] rd_vld,
    output logic [num_ports-1:0] rd_eop,
    output word_t                rd_data
);

    buf_wr_if wr_bus ();
    buf_rd_if rd_bus ();

    pkt_ingress ingress_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .full        (full),
        .almost_full (almost_full),
        .wr          (wr_bus.writer)
    );

    page_buffer buffer_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr_bus.buffer),
        .rd    (rd_bus.buffer)
    );

    pkt_egress egress_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_vld  (rd_vld),
        .rd_eop  (rd_eop),
        .rd_data (rd_data),
        .rd      (rd_bus.reader)
    );

endmodule

/* bench/switch_tb.sv */
`timescale 1ns/1ps

module switch_tb import sw_cfg_pkg::*, pkt_fmt_pkg::*; ();

    localparam int max_pkts    = 128;
    localparam int wait_limit  = 5000;
    localparam int drain_limit = 20000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 wr_sop;
    logic                 wr_eop;
    logic                 wr_vld;
    word_t                wr_data;
    logic                 full;
    logic                 almost_full;
    logic [num_ports-1:0] ready;
    logic [num_ports-1:0] rd_sop;
    logic [num_ports-1:0] rd_vld;
    logic [num_ports-1:0] rd_eop;
    word_t                rd_data;

    logic [31:0] lfsr_state = 32'hbf6a_beb6;

    // stored packets and the per-queue model lists
    word_t pkt_words [max_pkts][64];
    len_t  pkt_lens  [max_pkts];
    int    num_made   = 0;
    int    model_q [num_ports*num_prios][$];
    int    used_pages = 0;
    prio_t prio_log [$];

    // receive side state
    logic  in_pkt = 1'b0;
    int    cur_id;
    int    cur_idx;
    int    cur_qid;
    port_t cur_port;
    port_t rx_port;

    int    checks   = 0;
    int    errors   = 0;
    int    rx_count = 0;
    int    err_before;
    int    id;
    int    n;
    int    waited;
    int    batch [$];
    logic  sender_done;

    switch_top switch_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .full        (full),
        .almost_full (almost_full),
        .ready       (ready),
        .rd_sop      (rd_sop),
        .rd_vld      (rd_vld),
        .rd_eop      (rd_eop),
        .rd_data     (rd_data)
    );

    always #20 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic len_t rand_len();
        len_t len;
        len = len_t'(rand_bits(6));
        if (len < len_t'(2)) begin
            len = len + len_t'(2);
        end
        return len;
    endfunction

    function automatic int pages_of(input len_t len);
        return (int'(len) + page_words - 1) / page_words;
    endfunction

    function automatic int pending_packets();
        int total;
        total = int'(in_pkt);
        for (int q = 0; q < num_ports * num_prios; q++) begin
            total += model_q[q].size();
        end
        return total;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_port(input string name, input port_t got, input port_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_logic(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("ERROR: timed out %s", what);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, errors - err_before);
    endtask

    task automatic make_packet(input port_t dest, input prio_t prio, input len_t len,
                               output int pkt_id);
        word_t hdr;
        hdr = word_t'(rand_bits(16));
        hdr[dest_lsb +: $bits(port_t)] = dest;
        hdr[prio_lsb +: $bits(prio_t)] = prio;
        hdr[len_lsb +: $bits(len_t)]   = len;
        pkt_id = num_made;
        pkt_lens[pkt_id] = len;
        pkt_words[pkt_id][0] = hdr;
        for (int i = 1; i < int'(len); i++) begin
            pkt_words[pkt_id][i] = word_t'(rand_bits(16));
        end
        num_made++;
    endtask

    // holds off while full, then sends one word per cycle
    task automatic send_packet(input int pkt_id);
        int qid;
        int wait_cnt;
        qid = int'(pkt_words[pkt_id][0][dest_lsb +: $bits(port_t)]) * num_prios
            + int'(pkt_words[pkt_id][0][prio_lsb +: $bits(prio_t)]);
        wait_cnt = 0;
        @(negedge clk);
        while (full) begin
            if (wait_cnt >= wait_limit) begin
                abort_on_timeout("waiting for full to drop before a packet");
            end
            @(negedge clk);
            wait_cnt++;
        end
        model_q[qid].push_back(pkt_id);
        used_pages += pages_of(pkt_lens[pkt_id]);
        for (int i = 0; i < int'(pkt_lens[pkt_id]); i++) begin
            @(posedge clk);
            wr_vld  <= 1'b1;
            wr_sop  <= i == 0;
            wr_eop  <= i == int'(pkt_lens[pkt_id]) - 1;
            wr_data <= pkt_words[pkt_id][i];
        end
        @(posedge clk);
        wr_vld <= 1'b0;
        wr_sop <= 1'b0;
        wr_eop <= 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int wait_cnt;
        wait_cnt = 0;
        while (pending_packets() != 0) begin
            if (wait_cnt >= drain_limit) begin
                abort_on_timeout(what);
            end
            @(negedge clk);
            wait_cnt++;
        end
    endtask

    // receive monitor, matched against the model list of its port and header priority
    always @(negedge clk) begin
        if (rst_n) begin
            if (((rd_sop | rd_eop) & ~rd_vld) != '0) begin
                report_error("rd_sop or rd_eop raised without rd_vld");
            end
            if (rd_vld != '0) begin
                check_logic("rd_vld one-hot", $onehot(rd_vld), 1'b1);
                for (int p = 0; p < num_ports; p++) begin
                    if (rd_vld[p]) begin
                        rx_port = port_t'(p);
                    end
                end
                if (!in_pkt) begin
                    check_logic("rd_sop", rd_sop[rx_port], 1'b1);
                    cur_qid  = int'(rx_port) * num_prios
                             + int'(rd_data[prio_lsb +: $bits(prio_t)]);
                    cur_idx  = 0;
                    in_pkt   = 1'b1;
                    if (model_q[cur_qid].size() == 0) begin
                        report_error("packet arrived while its queue held no packet");
                        cur_id = -1;
                    end else begin
                        cur_id   = model_q[cur_qid][0];
                        cur_port = port_t'(pkt_words[cur_id][0][dest_lsb +: $bits(port_t)]);
                        prio_log.push_back(rd_data[prio_lsb +: $bits(prio_t)]);
                    end
                end else begin
                    check_logic("rd_sop", rd_sop[rx_port], 1'b0);
                    check_port("rd_vld port", rx_port, cur_port);
                end
                if (cur_id >= 0) begin
                    check_word("rd_data", rd_data, pkt_words[cur_id][cur_idx]);
                    check_logic("rd_eop", rd_eop[rx_port],
                                cur_idx == int'(pkt_lens[cur_id]) - 1);
                    if (cur_idx >= int'(pkt_lens[cur_id]) - 1) begin
                        void'(model_q[cur_qid].pop_front());
                        used_pages -= pages_of(pkt_lens[cur_id]);
                        rx_count++;
                        in_pkt = 1'b0;
                    end
                end else if (rd_eop[rx_port]) begin
                    in_pkt = 1'b0;
                end
                cur_idx++;
            end
        end
    end

    initial begin
        rst_n   = 1'b0;
        wr_sop  = 1'b0;
        wr_eop  = 1'b0;
        wr_vld  = 1'b0;
        wr_data = '0;
        ready   = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        err_before = errors;
        @(negedge clk);
        check_logic("rd_sop", |rd_sop, 1'b0);
        check_logic("rd_vld", |rd_vld, 1'b0);
        check_logic("rd_eop", |rd_eop, 1'b0);
        check_logic("full", full, 1'b0);
        check_logic("almost_full", almost_full, 1'b0);
        end_test("reset");

        err_before = errors;
        @(posedge clk);
        ready <= '1;
        for (int p = 0; p < num_ports; p++) begin
            make_packet(port_t'(p), prio_t'(rand_bits(2)), rand_len(), id);
            send_packet(id);
        end
        wait_drain("waiting for forwarded packets");
        end_test("forward");

        err_before = errors;
        @(posedge clk);
        ready <= '0;
        for (int k = 0; k < 8; k++) begin
            make_packet(port_t'(0), prio_t'(rand_bits(2)), rand_len(), id);
            send_packet(id);
        end
        // last enqueue lands two cycles after the eop word
        repeat (4) @(posedge clk);
        prio_log.delete();
        ready <= num_ports'(1);
        wait_drain("waiting for port 0 packets");
        for (int i = 1; i < prio_log.size(); i++) begin
            check_logic("priority order", prio_log[i] >= prio_log[i-1], 1'b1);
        end
        end_test("priority");

        err_before = errors;
        @(posedge clk);
        ready <= '0;
        n = 0;
        while (num_pages - used_pages >= full_level && n < 64) begin
            make_packet(port_t'(rand_bits(2)), prio_t'(rand_bits(2)), rand_len(), id);
            send_packet(id);
            @(negedge clk);
            @(negedge clk);
            check_logic("full", full, (num_pages - used_pages) < full_level);
            check_logic("almost_full", almost_full,
                        (num_pages - used_pages) < almost_full_level);
            n++;
        end
        check_logic("full", full, 1'b1);
        @(posedge clk);
        ready <= '1;
        wait_drain("draining the full buffer");
        waited = 0;
        while (full || almost_full) begin
            if (waited >= wait_limit) begin
                abort_on_timeout("waiting for the flags to drop");
            end
            @(negedge clk);
            waited++;
        end
        end_test("flags");

        err_before = errors;
        batch.delete();
        for (int k = 0; k < 40; k++) begin
            make_packet(port_t'(rand_bits(2)), prio_t'(rand_bits(2)), rand_len(), id);
            batch.push_back(id);
        end
        sender_done = 1'b0;
        fork
            begin
                foreach (batch[k]) begin
                    send_packet(batch[k]);
                end
                sender_done = 1'b1;
            end
            begin
                while (!sender_done) begin
                    @(posedge clk);
                    ready <= num_ports'(rand_bits(num_ports));
                end
            end
        join
        @(posedge clk);
        ready <= '1;
        wait_drain("draining random traffic");
        end_test("backpressure");

        $display("checks %0d, errors %0d, packets %0d", checks, errors, rx_count);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
rtl/sw_cfg_pkg.sv
rtl/pkt_fmt_pkg.sv
rtl/buf_wr_if.sv
rtl/buf_rd_if.sv
rtl/page_free_list.sv
rtl/page_buffer.sv
rtl/pkt_ingress.sv
rtl/pkt_egress.sv
rtl/switch_top.sv
bench/switch_tb.sv
